/* sim.f */
+incdir+test
design/kws_pre_pkg.sv
design/ahb_slave_port.sv
design/pre_regs.sv
design/coef_ram.sv
design/stream_fifo.sv
design/window_engine.sv
design/kws_preprocess_top.sv
test/tb_kws_preprocess.sv

/* test/tb_ahb_tasks.svh */
// AHB access and compare helpers
`ifndef tb_ahb_tasks_svh
`define tb_ahb_tasks_svh

////////////////////////////// bus access
task automatic bus_write(input kws_pre_pkg::addr_t addr, input kws_pre_pkg::word_t data);
  ahb_req.hsel   = 1'b1;                        // address phase
  ahb_req.haddr  = addr;
  ahb_req.htrans = kws_pre_pkg::htrans_nonseq;
  ahb_req.hwrite = 1'b1;
  @(posedge hclk0);
  #1;
  ahb_req.hsel   = 1'b0;                        // data phase, bus idle behind it
  ahb_req.htrans = 2'b00;
  ahb_req.hwdata = data;
  @(posedge hclk0);
  #1;
endtask

// read data is registered on the strobe, so it is taken one cycle later
task automatic bus_read(input kws_pre_pkg::addr_t addr, output kws_pre_pkg::word_t data);
  ahb_req.hsel   = 1'b1;
  ahb_req.haddr  = addr;
  ahb_req.htrans = kws_pre_pkg::htrans_nonseq;
  ahb_req.hwrite = 1'b0;
  @(posedge hclk0);
  #1;
  ahb_req.hsel   = 1'b0;
  ahb_req.htrans = 2'b00;
  @(posedge hclk0);
  #1;
  data = hrdata;                                // stable here
endtask

////////////////////////////// compares
task automatic check_word(input string name, input kws_pre_pkg::word_t got,
                          input kws_pre_pkg::word_t exp);
  if (got !== exp) begin
    report_failure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                             $time, name, got, exp));
  end
endtask

task automatic check_result(input string name, input kws_pre_pkg::result_t got,
                            input kws_pre_pkg::result_t exp);
  if (got !== exp) begin
    report_failure($sformatf(
      "CHECK FAILED at %0t: %s got value %0d last %b expected value %0d last %b",
      $time, name, got.value, got.last, exp.value, exp.last));
  end
endtask

////////////////////////////// reference model
// exact product, floor shift, then clamp to the 16 bit range
function automatic kws_pre_pkg::sample_t exp_result(input kws_pre_pkg::sample_t sample,
                                                    input kws_pre_pkg::sample_t coef,
                                                    input int unsigned shift);
  longint prod;
  longint scaled;
  prod   = longint'(sample) * longint'(coef);
  scaled = prod >>> shift;
  if (scaled > 32767) begin
    return 16'sh7FFF;
  end
  if (scaled < -32768) begin
    return 16'sh8000;
  end
  return kws_pre_pkg::sample_t'(scaled);
endfunction

`endif

/* test/tb_kws_preprocess.sv */
// KWS front end testbench
`timescale 1ns/100ps

module tb_kws_preprocess;

  logic                   hclk0;
  logic                   hrst_b0;
  kws_pre_pkg::ahb_req_t  ahb_req;
  kws_pre_pkg::word_t     hrdata;
  kws_pre_pkg::sample_t   coef_model [kws_pre_pkg::n_coef];   // mirror of the table
  kws_pre_pkg::result_t   exp_q [$];                          // expected results in order
  kws_pre_pkg::result_t   got_q [$];                          // popped over the bus
  kws_pre_pkg::coef_idx_t sw_idx;                             // software frame index
  kws_pre_pkg::coef_idx_t m_len;
  int unsigned            m_shift;
  int unsigned            n_sent;
  int unsigned            n_checked;
  integer                 seed;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal;
  endtask

  `include "tb_ahb_tasks.svh"

  kws_preprocess_top i_dut (
    .hclk0   (hclk0),
    .hrst_b0 (hrst_b0),
    .ahb_req (ahb_req),
    .hrdata  (hrdata)
  );

  initial begin
    hclk0 = 1'b0;
    forever #4 hclk0 = ~hclk0;                                // 8 ns period
  end

  ////////////////////////////// checking process
  initial begin : compare_results
    kws_pre_pkg::result_t got;
    forever begin
      @(posedge hclk0);
      while (got_q.size() != 0) begin
        got = got_q.pop_front();
        if (exp_q.size() == 0) begin
          report_failure("a result arrived with no sample outstanding");
        end
        check_result("popped result", got, exp_q.pop_front());
        n_checked++;
      end
    end
  end

  ////////////////////////////// stimulus helpers
  task automatic set_ctrl(input logic enable, input logic clear,
                          input logic [3:0] shift, input kws_pre_pkg::coef_idx_t len_m1);
    kws_pre_pkg::word_t w;
    kws_pre_pkg::word_t rd;
    w = '0;
    w[kws_pre_pkg::ctrl_enable_bit] = enable;
    w[kws_pre_pkg::ctrl_clear_bit]  = clear;
    w[kws_pre_pkg::ctrl_shift_lsb +: 4] = shift;
    w[kws_pre_pkg::ctrl_len_lsb +: 6]   = len_m1;
    bus_write(kws_pre_pkg::ctrl_addr, w);
    m_shift = shift;
    m_len   = len_m1;
    if (!enable) begin
      sw_idx = '0;                                            // engine restarts its frame
    end
    w[kws_pre_pkg::ctrl_clear_bit] = 1'b0;                    // clear never reads back
    bus_read(kws_pre_pkg::ctrl_addr, rd);
    check_word("ctrl readback", rd, w);
  endtask

  task automatic write_coef(input int idx, input kws_pre_pkg::word_t w);
    bus_write(kws_pre_pkg::addr_t'(kws_pre_pkg::coef_base + idx * 4), w);
    coef_model[idx] = w[15:0];                                // low half only
  endtask

  task automatic model_push(input kws_pre_pkg::sample_t s);
    kws_pre_pkg::result_t r;
    r.value = exp_result(s, coef_model[sw_idx], m_shift);
    r.last  = (sw_idx == m_len);                              // frame end
    sw_idx  = r.last ? '0 : sw_idx + 1'b1;
    exp_q.push_back(r);
    n_sent++;
  endtask

  function automatic kws_pre_pkg::word_t make_status(input int unsigned n_in,
                                                     input int unsigned n_out,
                                                     input logic ovf);
    kws_pre_pkg::word_t w;
    w = '0;
    w[3:0]  = n_in;
    w[11:8] = n_out;
    w[16]   = ovf;
    return w;
  endfunction

  // pop everything the status says is waiting
  task automatic pop_results();
    kws_pre_pkg::word_t st;
    kws_pre_pkg::word_t rw;
    kws_pre_pkg::result_t r;
    bus_read(kws_pre_pkg::status_addr, st);
    for (int k = 0; k < st[11:8]; k++) begin
      bus_read(kws_pre_pkg::result_addr, rw);
      if (!rw[kws_pre_pkg::result_valid_bit]) begin
        report_failure("result read came back invalid while the output queue held data");
      end
      r.value = rw[15:0];
      r.last  = rw[kws_pre_pkg::result_last_bit];
      check_word("result word format", rw, {1'b1, r.last, {14{r.value[15]}}, r.value});
      got_q.push_back(r);
    end
  endtask

  task automatic send_sample(input kws_pre_pkg::sample_t s);
    kws_pre_pkg::word_t st;
    bit room;
    room = 1'b0;
    for (int t = 0; t < 200 && !room; t++) begin
      bus_read(kws_pre_pkg::status_addr, st);
      if (st[3:0] < kws_pre_pkg::fifo_depth) room = 1'b1;
      else pop_results();                                     // free the engine
    end
    if (!room) report_failure("timeout waiting for space in the input queue");
    bus_write(kws_pre_pkg::data_addr, {16'h0000, s});
    model_push(s);
  endtask

  task automatic wait_drained(input string what);
    bit done;
    done = 1'b0;
    for (int t = 0; t < 200 && !done; t++) begin
      if (exp_q.size() == 0 && got_q.size() == 0) done = 1'b1;
      else pop_results();
    end
    if (!done) report_failure({"timeout waiting for all results during ", what});
  endtask

  ////////////////////////////// main sequence
  initial begin : stimulus
    kws_pre_pkg::word_t   rd;
    kws_pre_pkg::sample_t s;
    seed      = 60;
    ahb_req   = '0;
    ahb_req.hready_in = 1'b1;                                 // zero wait state bus
    hrst_b0   = 1'b0;
    sw_idx    = '0;
    m_len     = '0;
    m_shift   = 0;
    n_sent    = 0;
    n_checked = 0;
    repeat (4) @(posedge hclk0);
    #1;
    hrst_b0 = 1'b1;

    // reset values
    bus_read(kws_pre_pkg::ctrl_addr, rd);
    check_word("ctrl after reset", rd, '0);
    bus_read(kws_pre_pkg::status_addr, rd);
    check_word("status after reset", rd, '0);
    bus_read(kws_pre_pkg::result_addr, rd);
    check_word("result read of empty queue", rd, '0);

    // random window with a frame of 8 over three frames
    for (int i = 0; i < kws_pre_pkg::n_coef; i++) write_coef(i, $random(seed));
    set_ctrl(1'b1, 1'b0, 4'd14, 6'd7);
    for (int i = 0; i < 24; i++) begin
      send_sample($random(seed));
      pop_results();
    end
    wait_drained("random stream");

    // full scale inputs with no shift
    set_ctrl(1'b0, 1'b0, 4'd0, 6'd3);
    write_coef(0, 32'h0000_7FFF);
    write_coef(1, 32'hFFFF_8000);
    write_coef(2, 32'h0000_7FFF);
    write_coef(3, 32'h0000_8000);
    set_ctrl(1'b1, 1'b0, 4'd0, 6'd3);
    send_sample(16'sh7FFF);                                   // clamps high
    send_sample(16'sh7FFF);                                   // clamps low
    send_sample(16'sh8000);
    send_sample(16'sh8000);
    wait_drained("saturation");

    // frame restart when enable toggles mid frame
    set_ctrl(1'b0, 1'b0, 4'd12, 6'd4);
    set_ctrl(1'b1, 1'b0, 4'd12, 6'd4);
    repeat (3) send_sample($random(seed));
    wait_drained("partial frame");
    set_ctrl(1'b0, 1'b0, 4'd12, 6'd4);
    set_ctrl(1'b1, 1'b0, 4'd12, 6'd4);
    repeat (10) send_sample($random(seed));
    wait_drained("frame restart");

    // overflow while disabled
    set_ctrl(1'b0, 1'b0, 4'd12, 6'd4);
    for (int i = 0; i < kws_pre_pkg::fifo_depth + 3; i++) begin
      s = $random(seed);
      bus_write(kws_pre_pkg::data_addr, {16'h0000, s});
      if (i < kws_pre_pkg::fifo_depth) model_push(s);         // the rest are dropped
    end
    bus_read(kws_pre_pkg::status_addr, rd);
    check_word("status at overflow", rd, make_status(kws_pre_pkg::fifo_depth, 0, 1'b1));
    set_ctrl(1'b0, 1'b1, 4'd12, 6'd4);
    bus_read(kws_pre_pkg::status_addr, rd);
    check_word("status after clear", rd, make_status(kws_pre_pkg::fifo_depth, 0, 1'b0));
    set_ctrl(1'b1, 1'b0, 4'd12, 6'd4);
    wait_drained("overflow drain");
    bus_read(kws_pre_pkg::status_addr, rd);
    check_word("status when idle", rd, '0);

    if (n_checked != n_sent) begin
      report_failure("number of compared results differs from samples accepted");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

/* design/kws_preprocess_top.sv */
// KWS preprocessing front end top level
`timescale 1ns/100ps

module kws_preprocess_top (
  input  logic                  hclk0,
  input  logic                  hrst_b0,
  input  kws_pre_pkg::ahb_req_t ahb_req,
  output kws_pre_pkg::word_t    hrdata
);

  kws_pre_pkg::reg_acc_t  reg_acc;       // decoded bus access
  kws_pre_pkg::pre_cfg_t  cfg;
  kws_pre_pkg::coef_wr_t  coef_wr;
  logic                   sample_push;
  kws_pre_pkg::sample_t   sample_data;
  logic                   in_full;
  logic                   in_empty;
  kws_pre_pkg::count_t    in_count;
  logic                   in_pop;
  kws_pre_pkg::sample_t   in_data;       // input queue head
  kws_pre_pkg::coef_idx_t coef_index;
  kws_pre_pkg::sample_t   coef_value;
  logic                   out_push;
  kws_pre_pkg::result_t   out_data;
  logic                   result_pop;
  kws_pre_pkg::result_t   result;        // output queue head
  kws_pre_pkg::count_t    out_count;
  logic                   out_empty;

  ////////////////////////////// bus side
  ahb_slave_port u_port (
    .hclk0   (hclk0),
    .hrst_b0 (hrst_b0),
    .ahb_req (ahb_req),
    .reg_acc (reg_acc)
  );

  pre_regs u_regs (
    .hclk0       (hclk0),
    .hrst_b0     (hrst_b0),
    .reg_acc     (reg_acc),
    .hrdata      (hrdata),
    .cfg         (cfg),
    .coef_wr     (coef_wr),
    .sample_push (sample_push),
    .sample_data (sample_data),
    .in_full     (in_full),
    .in_count    (in_count),
    .result_pop  (result_pop),
    .result      (result),
    .out_count   (out_count),
    .out_empty   (out_empty)
  );

  coef_ram u_coef (
    .hclk0    (hclk0),
    .coef_wr  (coef_wr),
    .rd_index (coef_index),
    .rd_value (coef_value)
  );

  ////////////////////////////// streaming path
  stream_fifo #(.payload_t(kws_pre_pkg::sample_t)) u_in_fifo (
    .hclk0     (hclk0),
    .hrst_b0   (hrst_b0),
    .push      (sample_push),
    .push_data (sample_data),
    .pop       (in_pop),
    .pop_data  (in_data),
    .full      (in_full),
    .empty     (in_empty),
    .count     (in_count)
  );

  window_engine u_engine (
    .hclk0      (hclk0),
    .hrst_b0    (hrst_b0),
    .cfg        (cfg),
    .in_data    (in_data),
    .in_empty   (in_empty),
    .in_pop     (in_pop),
    .coef_index (coef_index),
    .coef_value (coef_value),
    .out_count  (out_count),
    .out_push   (out_push),
    .out_data   (out_data)
  );

  // engine reserves space itself, full flag not needed here
  stream_fifo #(.payload_t(kws_pre_pkg::result_t)) u_out_fifo (
    .hclk0     (hclk0),
    .hrst_b0   (hrst_b0),
    .push      (out_push),
    .push_data (out_data),
    .pop       (result_pop),
    .pop_data  (result),
    .full      (),
    .empty     (out_empty),
    .count     (out_count)
  );

endmodule

/* design/window_engine.sv */
// Window multiply, shift and saturate pipeline
`timescale 1ns/100ps

module window_engine (
  input  logic                   hclk0,
  input  logic                   hrst_b0,
  input  kws_pre_pkg::pre_cfg_t  cfg,
  input  kws_pre_pkg::sample_t   in_data,
  input  logic                   in_empty,
  output logic                   in_pop,
  output kws_pre_pkg::coef_idx_t coef_index,
  input  kws_pre_pkg::sample_t   coef_value,
  input  kws_pre_pkg::count_t    out_count,
  output logic                   out_push,
  output kws_pre_pkg::result_t   out_data
);

  kws_pre_pkg::coef_idx_t frame_idx;   // position inside the frame
  logic                   frame_end;
  logic [4:0]             occupancy;   // queued plus in flight
  logic                   s1_valid;
  kws_pre_pkg::sample_t   s1_sample;
  logic                   s1_last;
  logic signed [31:0]     product;
  logic signed [31:0]     shifted;
  kws_pre_pkg::sample_t   saturated;

  ////////////////////////////// stage one, pop and table lookup
  always_comb begin
    occupancy  = out_count + s1_valid + out_push;
    frame_end  = (frame_idx == cfg.frame_len);
    in_pop     = cfg.enable & ~in_empty &
                 (occupancy < 5'(kws_pre_pkg::fifo_depth));   // never stalls mid flight
    coef_index = frame_idx;                                   // table read lands with s1
  end

  always_ff @(posedge hclk0 or negedge hrst_b0) begin
    if (!hrst_b0) begin
      frame_idx <= '0;
      s1_valid  <= 1'b0;
    end else begin
      s1_valid <= in_pop;
      if (!cfg.enable) begin
        frame_idx <= '0;                                      // restart on disable
      end else if (in_pop) begin
        frame_idx <= frame_end ? '0 : frame_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge hclk0) begin
    if (in_pop) begin
      s1_sample <= in_data;
      s1_last   <= frame_end;                                 // last position of the frame
    end
  end

  ////////////////////////////// stage two, multiply, shift, saturate
  always_comb begin
    product = s1_sample * coef_value;                         // full 32 bit product
    shifted = product >>> cfg.shift;                          // arithmetic
    if (shifted[31:15] == {17{shifted[31]}}) begin
      saturated = shifted[15:0];                              // fits in 16 bits
    end else if (shifted[31]) begin
      saturated = 16'sh8000;                                  // clamp negative
    end else begin
      saturated = 16'sh7FFF;                                  // clamp positive
    end
  end

  always_ff @(posedge hclk0 or negedge hrst_b0) begin
    if (!hrst_b0) begin
      out_push <= 1'b0;
    end else begin
      out_push <= s1_valid;                                   // two cycles after the pop
    end
  end

  always_ff @(posedge hclk0) begin
    if (s1_valid) begin
      out_data.value <= saturated;
      out_data.last  <= s1_last;
    end
  end

  // space was reserved at pop time, so the output queue always has room
  a_no_push_full: assert property (
    @(posedge hclk0) disable iff (!hrst_b0)
    out_push |-> (out_count < kws_pre_pkg::count_t'(kws_pre_pkg::fifo_depth))
  );

endmodule

/* design/stream_fifo.sv */
// Synchronous queue with fall-through head
`timescale 1ns/100ps

module stream_fifo #(
  parameter type payload_t = kws_pre_pkg::sample_t
) (
  input  logic                hclk0,
  input  logic                hrst_b0,
  input  logic                push,
  input  payload_t            push_data,
  input  logic                pop,
  output payload_t            pop_data,
  output logic                full,
  output logic                empty,
  output kws_pre_pkg::count_t count
);

  payload_t                             mem [kws_pre_pkg::fifo_depth];
  logic [kws_pre_pkg::fifo_ptr_w-1:0]   wr_ptr;      // wraps at depth
  logic [kws_pre_pkg::fifo_ptr_w-1:0]   rd_ptr;

  ////////////////////////////// pointers and fill level
  always_ff @(posedge hclk0 or negedge hrst_b0) begin
    if (!hrst_b0) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;                      // both or neither
      endcase
    end
  end

  ////////////////////////////// storage
  always_ff @(posedge hclk0) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_comb begin
    pop_data = mem[rd_ptr];                           // head visible without a pop
    full     = (count == kws_pre_pkg::count_t'(kws_pre_pkg::fifo_depth));
    empty    = (count == '0);
  end

  // producers and consumers must check the flags first
  a_no_overrun: assert property (
    @(posedge hclk0) disable iff (!hrst_b0)
    push |-> !full
  );

  a_no_underrun: assert property (
    @(posedge hclk0) disable iff (!hrst_b0)
    pop |-> !empty
  );

endmodule

/* design/coef_ram.sv */
// Cosine coefficient table
`timescale 1ns/100ps

module coef_ram (
  input  logic                   hclk0,
  input  kws_pre_pkg::coef_wr_t  coef_wr,
  input  kws_pre_pkg::coef_idx_t rd_index,
  output kws_pre_pkg::sample_t   rd_value
);

  ////////////////////////////// storage
  // one 16 bit coefficient per frame position
  kws_pre_pkg::sample_t mem [kws_pre_pkg::n_coef];

  // bus side write port
  always_ff @(posedge hclk0) begin
    if (coef_wr.strobe) begin
      mem[coef_wr.index] <= coef_wr.value;           // low half of the bus word
    end
  end

  ////////////////////////////// engine side read
  // registered read, value appears the cycle after the index,
  // which lines it up with the popped sample in the engine
  always_ff @(posedge hclk0) begin
    rd_value <= mem[rd_index];                       // read every cycle
  end

endmodule

/* design/pre_regs.sv */
// Control and status register block
`timescale 1ns/100ps

module pre_regs (
  input  logic                  hclk0,
  input  logic                  hrst_b0,
  input  kws_pre_pkg::reg_acc_t reg_acc,
  output kws_pre_pkg::word_t    hrdata,
  output kws_pre_pkg::pre_cfg_t cfg,
  output kws_pre_pkg::coef_wr_t coef_wr,
  output logic                  sample_push,
  output kws_pre_pkg::sample_t  sample_data,
  input  logic                  in_full,
  input  kws_pre_pkg::count_t   in_count,
  output logic                  result_pop,
  input  kws_pre_pkg::result_t  result,
  input  kws_pre_pkg::count_t   out_count,
  input  logic                  out_empty
);

  logic               wr_acc;        // write strobe
  logic               rd_acc;        // read strobe
  logic               ctrl_wr;
  logic               data_wr;
  logic               coef_sel;      // offset inside the table window
  logic               overflow_q;    // sticky, sample lost at full queue
  kws_pre_pkg::word_t ctrl_word;
  kws_pre_pkg::word_t status_word;
  kws_pre_pkg::word_t result_word;

  ////////////////////////////// decode
  always_comb begin
    wr_acc   = reg_acc.strobe & reg_acc.write;
    rd_acc   = reg_acc.strobe & ~reg_acc.write;
    ctrl_wr  = wr_acc & (reg_acc.addr == kws_pre_pkg::ctrl_addr);
    data_wr  = wr_acc & (reg_acc.addr == kws_pre_pkg::data_addr);
    coef_sel = (reg_acc.addr[11:8] == kws_pre_pkg::coef_base[11:8]);   // 0x100..0x1FC

    coef_wr.strobe = wr_acc & coef_sel;
    coef_wr.index  = reg_acc.addr[7:2];                    // word index
    coef_wr.value  = reg_acc.wdata[15:0];

    sample_push = data_wr & ~in_full;                      // dropped when full
    sample_data = reg_acc.wdata[15:0];

    result_pop  = rd_acc & (reg_acc.addr == kws_pre_pkg::result_addr) & ~out_empty;
  end

  ////////////////////////////// control and overflow
  always_ff @(posedge hclk0 or negedge hrst_b0) begin
    if (!hrst_b0) begin
      cfg        <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (ctrl_wr) begin
        cfg.enable    <= reg_acc.wdata[kws_pre_pkg::ctrl_enable_bit];
        cfg.shift     <= reg_acc.wdata[kws_pre_pkg::ctrl_shift_lsb +: kws_pre_pkg::shift_w];
        cfg.frame_len <= reg_acc.wdata[kws_pre_pkg::ctrl_len_lsb +: kws_pre_pkg::coef_idx_w];
      end
      if (data_wr && in_full) begin
        overflow_q <= 1'b1;
      end else if (ctrl_wr && reg_acc.wdata[kws_pre_pkg::ctrl_clear_bit]) begin
        overflow_q <= 1'b0;                                // clear bit is not stored
      end
    end
  end

  ////////////////////////////// read words
  always_comb begin
    ctrl_word = '0;
    ctrl_word[kws_pre_pkg::ctrl_enable_bit] = cfg.enable;
    ctrl_word[kws_pre_pkg::ctrl_shift_lsb +: kws_pre_pkg::shift_w] = cfg.shift;
    ctrl_word[kws_pre_pkg::ctrl_len_lsb +: kws_pre_pkg::coef_idx_w] = cfg.frame_len;

    status_word = '0;
    status_word[kws_pre_pkg::status_in_lsb +: kws_pre_pkg::count_w]  = in_count;
    status_word[kws_pre_pkg::status_out_lsb +: kws_pre_pkg::count_w] = out_count;
    status_word[kws_pre_pkg::status_ovf_bit] = overflow_q;

    result_word = '0;                                      // empty queue reads as invalid
    if (!out_empty) begin
      result_word[kws_pre_pkg::result_valid_bit] = 1'b1;
      result_word[kws_pre_pkg::result_last_bit]  = result.last;
      result_word[kws_pre_pkg::result_last_bit-1:0] =
        {{(kws_pre_pkg::result_last_bit - 16){result.value[15]}}, result.value};   // sign extend
    end
  end

  // read data registered on the strobe, valid one cycle later
  always_ff @(posedge hclk0) begin
    if (rd_acc) begin
      case (reg_acc.addr)
        kws_pre_pkg::ctrl_addr:   hrdata <= ctrl_word;
        kws_pre_pkg::status_addr: hrdata <= status_word;
        kws_pre_pkg::result_addr: hrdata <= result_word;   // head of queue, popped now
        default:                  hrdata <= '0;            // table is write only
      endcase
    end
  end

endmodule

/* design/ahb_slave_port.sv */
// AHB-lite slave port
`timescale 1ns/100ps

module ahb_slave_port (
  input  logic                  hclk0,
  input  logic                  hrst_b0,
  input  kws_pre_pkg::ahb_req_t ahb_req,
  output kws_pre_pkg::reg_acc_t reg_acc
);

  logic               accept;       // address phase taken this cycle
  logic               dphase_q;     // data phase pending
  logic               write_q;
  kws_pre_pkg::addr_t addr_q;

  ////////////////////////////// address phase
  always_comb begin
    accept = ahb_req.hsel & ahb_req.hready_in &
             ((ahb_req.htrans == kws_pre_pkg::htrans_nonseq) |
              (ahb_req.htrans == kws_pre_pkg::htrans_seq));   // idle and busy ignored
  end

  always_ff @(posedge hclk0 or negedge hrst_b0) begin
    if (!hrst_b0) begin
      dphase_q <= 1'b0;
    end else begin
      dphase_q <= accept;                                   // back to back keeps it high
    end
  end

  always_ff @(posedge hclk0) begin
    if (accept) begin
      write_q <= ahb_req.hwrite;                            // qualifiers held for data phase
      addr_q  <= ahb_req.haddr;
    end
  end

  ////////////////////////////// data phase strobe
  always_comb begin
    reg_acc.strobe = dphase_q;
    reg_acc.write  = write_q;
    reg_acc.addr   = addr_q;
    reg_acc.wdata  = ahb_req.hwdata;                        // write data live from the bus
  end

  // a lone transfer never gives a strobe longer than one cycle
  a_strobe_single: assert property (
    @(posedge hclk0) disable iff (!hrst_b0)
    (accept ##1 !accept) |=> !reg_acc.strobe
  );

endmodule

/* design/kws_pre_pkg.sv */
// KWS front end shared definitions
package kws_pre_pkg;

  ////////////////////////////// widths and sizes
  typedef logic [31:0]        word_t;         // bus word
  typedef logic signed [15:0] sample_t;       // audio sample, coefficient and result value
  typedef logic [11:0]        addr_t;         // byte offset inside the slave

  localparam int unsigned n_coef     = 64;    // cosine table entries
  localparam int unsigned coef_idx_w = 6;
  localparam int unsigned fifo_depth = 8;     // entries per queue
  localparam int unsigned fifo_ptr_w = 3;     // depth is a power of two
  localparam int unsigned count_w    = 4;     // holds 0..fifo_depth
  localparam int unsigned shift_w    = 4;

  typedef logic [coef_idx_w-1:0] coef_idx_t;
  typedef logic [count_w-1:0]    count_t;

  ////////////////////////////// AHB transfer types
  localparam logic [1:0] htrans_nonseq = 2'b10;
  localparam logic [1:0] htrans_seq    = 2'b11;

  ////////////////////////////// address map
  localparam addr_t ctrl_addr   = 12'h000;
  localparam addr_t status_addr = 12'h004;
  localparam addr_t data_addr   = 12'h008;    // sample push
  localparam addr_t result_addr = 12'h00C;    // result read with pop
  localparam addr_t coef_base   = 12'h100;    // one word per table entry

  // control fields
  localparam int unsigned ctrl_enable_bit = 0;
  localparam int unsigned ctrl_clear_bit  = 1;   // write one to clear overflow
  localparam int unsigned ctrl_shift_lsb  = 4;
  localparam int unsigned ctrl_len_lsb    = 16;  // frame length minus one

  // status and result fields
  localparam int unsigned status_in_lsb    = 0;
  localparam int unsigned status_out_lsb   = 8;
  localparam int unsigned status_ovf_bit   = 16;
  localparam int unsigned result_valid_bit = 31;
  localparam int unsigned result_last_bit  = 30;

  ////////////////////////////// structs
  typedef struct packed {
    logic       hsel;
    addr_t      haddr;
    logic [1:0] htrans;
    logic       hwrite;
    word_t      hwdata;
    logic       hready_in;
  } ahb_req_t;

  typedef struct packed {
    logic  strobe;   // one cycle per accepted transfer
    logic  write;
    addr_t addr;
    word_t wdata;
  } reg_acc_t;

  typedef struct packed {
    logic      strobe;
    coef_idx_t index;
    sample_t   value;
  } coef_wr_t;

  typedef struct packed {
    logic               enable;
    logic [shift_w-1:0] shift;
    coef_idx_t          frame_len;
  } pre_cfg_t;

  typedef struct packed {
    sample_t value;
    logic    last;   // frame end marker
  } result_t;

endpackage
